// File: src/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Bus geometry
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int NBYTES = DATA_W / 8;

    // Byte offset bits inside a word
    localparam int BYTE_OFF_W = $clog2(NBYTES);

    // Memory depth and word index width
    localparam int RAM_WORDS = 256;
    localparam int WORD_IDX_W = $clog2(RAM_WORDS);

    // Byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // Data word as seen on the bus
    typedef logic [DATA_W-1:0] data_t;

    // Byte-lane strobes, all zero for a read
    typedef logic [NBYTES-1:0] strb_t;

    // Word index into the data memory
    typedef logic [WORD_IDX_W-1:0] word_idx_t;

endpackage

`default_nettype wire

// File: src/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int STATE_W = 2;
    localparam int SIZE_W = 2;
    localparam int OFFSET_W = 2;

    // Store commit FSM
    typedef enum logic [STATE_W-1:0] {
        IDLE,
        STORE_COMMIT_WAIT,
        STORE_REQ_SEND,
        STORE_REQ_WAIT
    } lsu_state_e;

    // Load access size
    typedef enum logic [SIZE_W-1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    // Byte offset of a load within its word
    typedef logic [OFFSET_W-1:0] offset_t;

endpackage

`default_nettype wire

// File: src/lsu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl (
    input  wire logic           clk,
    input  wire logic           rst,

    input  wire logic           cpu_valid,
    input  mem_pkg::strb_t      cpu_wstrb,
    input  wire logic           cpu_flush,
    input  wire logic           cpu_store_commit,
    input  wire logic           dcache_ready,

    output logic                cpu_ready,
    output logic                dcache_valid,
    output logic                store_sel,
    output logic                store_capture,
    output logic                load_issue
);

    lsu_pkg::lsu_state_e state;
    lsu_pkg::lsu_state_e next_state;

    logic is_store;
    logic accept;
    logic pending;

    // Nonzero strobe marks a store
    assign is_store = cpu_wstrb != '0;

    // Only new requests in IDLE with the previous access done
    assign cpu_ready = (state == lsu_pkg::IDLE) && (!pending || dcache_ready);
    assign accept = cpu_valid && cpu_ready && !cpu_flush;

    assign store_capture = accept && is_store;
    assign load_issue = accept && !is_store;

    // Loads go out at once, stores only after commit
    assign store_sel = state == lsu_pkg::STORE_REQ_SEND;
    assign dcache_valid = load_issue || store_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsu_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            lsu_pkg::IDLE: begin
                if (store_capture) begin
                    next_state = lsu_pkg::STORE_COMMIT_WAIT;
                end
            end
            lsu_pkg::STORE_COMMIT_WAIT: begin
                // Flush wins over a commit in the same cycle
                if (cpu_flush) begin
                    next_state = lsu_pkg::IDLE;
                end else if (cpu_store_commit) begin
                    next_state = lsu_pkg::STORE_REQ_SEND;
                end
            end
            lsu_pkg::STORE_REQ_SEND: begin
                next_state = lsu_pkg::STORE_REQ_WAIT;
            end
            lsu_pkg::STORE_REQ_WAIT: begin
                if (dcache_ready) begin
                    next_state = lsu_pkg::IDLE;
                end
            end
            default: begin
                next_state = lsu_pkg::IDLE;
            end
        endcase
    end

    // Outstanding memory access
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (dcache_valid) begin
            pending <= 1'b1;
        end else if (dcache_ready) begin
            pending <= 1'b0;
        end
    end

    // A held store must not reach memory before commit
    a_no_req_in_commit_wait: assert property (
        @(posedge clk) disable iff (rst)
        (state == lsu_pkg::STORE_COMMIT_WAIT) |-> !dcache_valid
    );

    a_capture_issue_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(store_capture && load_issue)
    );

endmodule

`default_nettype wire

// File: src/store_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module store_buffer (
    input  wire logic           clk,
    input  wire logic           rst,

    input  wire logic           store_capture,
    input  wire logic           store_sel,
    input  mem_pkg::addr_t      cpu_addr,
    input  mem_pkg::data_t      cpu_wdata,
    input  mem_pkg::strb_t      cpu_wstrb,

    output mem_pkg::addr_t      dcache_addr,
    output mem_pkg::data_t      dcache_wdata,
    output mem_pkg::strb_t      dcache_wstrb
);

    mem_pkg::addr_t held_addr;
    mem_pkg::data_t held_wdata;
    mem_pkg::strb_t held_wstrb;

    always_ff @(posedge clk) begin
        if (store_capture) begin
            held_addr  <= cpu_addr;
            held_wdata <= cpu_wdata;
        end
    end

    // Strobe doubles as the marker of a held store
    always_ff @(posedge clk) begin
        if (rst) begin
            held_wstrb <= '0;
        end else if (store_capture) begin
            held_wstrb <= cpu_wstrb;
        end
    end

    // Read requests carry no data and no strobe
    always_comb begin
        if (store_sel) begin
            dcache_addr  = held_addr;
            dcache_wdata = held_wdata;
            dcache_wstrb = held_wstrb;
        end else begin
            dcache_addr  = cpu_addr;
            dcache_wdata = '0;
            dcache_wstrb = '0;
        end
    end

    // Commit must find a captured store
    a_held_store_valid: assert property (
        @(posedge clk) disable iff (rst)
        store_sel |-> (held_wstrb != '0)
    );

endmodule

`default_nettype wire

// File: src/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wire logic           clk,
    input  wire logic           rst,

    input  wire logic           load_issue,
    input  mem_pkg::addr_t      cpu_addr,
    input  lsu_pkg::size_e      cpu_size,
    input  wire logic           cpu_unsigned,
    input  mem_pkg::data_t      dcache_rdata,
    input  wire logic           dcache_ready,

    output mem_pkg::data_t      cpu_rdata,
    output logic                cpu_data_valid
);

    lsu_pkg::offset_t ld_offset;
    lsu_pkg::size_e   ld_size;
    logic             ld_unsigned;
    logic             resp_pending;

    mem_pkg::data_t   shifted;
    logic             sign_bit;

    // Request attributes, reloaded by a back-to-back load
    always_ff @(posedge clk) begin
        if (load_issue) begin
            ld_offset   <= cpu_addr[lsu_pkg::OFFSET_W-1:0];
            ld_size     <= cpu_size;
            ld_unsigned <= cpu_unsigned;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_pending <= 1'b0;
        end else if (load_issue) begin
            resp_pending <= 1'b1;
        end else if (dcache_ready) begin
            resp_pending <= 1'b0;
        end
    end

    // Store acknowledgements never reach the CPU
    assign cpu_data_valid = resp_pending && dcache_ready;

    // Move the addressed lane down to bit 0
    assign shifted = dcache_rdata >> {ld_offset, 3'b000};

    always_comb begin
        sign_bit = 1'b0;
        case (ld_size)
            lsu_pkg::SIZE_BYTE: begin
                sign_bit  = !ld_unsigned && shifted[7];
                cpu_rdata = {{(mem_pkg::DATA_W - 8){sign_bit}}, shifted[7:0]};
            end
            lsu_pkg::SIZE_HALF: begin
                sign_bit  = !ld_unsigned && shifted[15];
                cpu_rdata = {{(mem_pkg::DATA_W - 16){sign_bit}}, shifted[15:0]};
            end
            default: begin
                cpu_rdata = dcache_rdata;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input  wire logic           clk,
    input  wire logic           rst,

    input  wire logic           dcache_valid,
    input  mem_pkg::addr_t      dcache_addr,
    input  mem_pkg::data_t      dcache_wdata,
    input  mem_pkg::strb_t      dcache_wstrb,

    output mem_pkg::data_t      dcache_rdata,
    output logic                dcache_ready
);

    mem_pkg::data_t    mem [mem_pkg::RAM_WORDS];
    mem_pkg::word_idx_t word_idx;

    // Memory starts out cleared
    initial begin
        for (int i = 0; i < mem_pkg::RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign word_idx = dcache_addr[mem_pkg::BYTE_OFF_W +: mem_pkg::WORD_IDX_W];

    always_ff @(posedge clk) begin
        if (dcache_valid) begin
            for (int i = 0; i < mem_pkg::NBYTES; i++) begin
                if (dcache_wstrb[i]) begin
                    mem[word_idx][i*8 +: 8] <= dcache_wdata[i*8 +: 8];
                end
            end
            // Zero strobe is a read
            if (dcache_wstrb == '0) begin
                dcache_rdata <= mem[word_idx];
            end
        end
    end

    // Every request is answered one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            dcache_ready <= 1'b0;
        end else begin
            dcache_ready <= dcache_valid;
        end
    end

    a_addr_in_range: assert property (
        @(posedge clk) disable iff (rst)
        dcache_valid |-> ((dcache_addr >> mem_pkg::BYTE_OFF_W) < mem_pkg::RAM_WORDS)
    );

endmodule

`default_nettype wire

// File: src/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  wire logic           clk,
    input  wire logic           rst,

    input  wire logic           cpu_valid,
    input  mem_pkg::addr_t      cpu_addr,
    input  mem_pkg::data_t      cpu_wdata,
    input  mem_pkg::strb_t      cpu_wstrb,
    input  lsu_pkg::size_e      cpu_size,
    input  wire logic           cpu_unsigned,
    input  wire logic           cpu_flush,
    input  wire logic           cpu_store_commit,

    output logic                cpu_ready,
    output mem_pkg::data_t      cpu_rdata,
    output logic                cpu_data_valid
);

    // Memory request and response
    logic           dcache_valid;
    mem_pkg::addr_t dcache_addr;
    mem_pkg::data_t dcache_wdata;
    mem_pkg::strb_t dcache_wstrb;
    mem_pkg::data_t dcache_rdata;
    logic           dcache_ready;

    logic store_sel;
    logic store_capture;
    logic load_issue;

    lsu_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .cpu_valid        (cpu_valid),
        .cpu_wstrb        (cpu_wstrb),
        .cpu_flush        (cpu_flush),
        .cpu_store_commit (cpu_store_commit),
        .dcache_ready     (dcache_ready),
        .cpu_ready        (cpu_ready),
        .dcache_valid     (dcache_valid),
        .store_sel        (store_sel),
        .store_capture    (store_capture),
        .load_issue       (load_issue)
    );

    store_buffer u_store_buffer (
        .clk           (clk),
        .rst           (rst),
        .store_capture (store_capture),
        .store_sel     (store_sel),
        .cpu_addr      (cpu_addr),
        .cpu_wdata     (cpu_wdata),
        .cpu_wstrb     (cpu_wstrb),
        .dcache_addr   (dcache_addr),
        .dcache_wdata  (dcache_wdata),
        .dcache_wstrb  (dcache_wstrb)
    );

    load_align u_load_align (
        .clk            (clk),
        .rst            (rst),
        .load_issue     (load_issue),
        .cpu_addr       (cpu_addr),
        .cpu_size       (cpu_size),
        .cpu_unsigned   (cpu_unsigned),
        .dcache_rdata   (dcache_rdata),
        .dcache_ready   (dcache_ready),
        .cpu_rdata      (cpu_rdata),
        .cpu_data_valid (cpu_data_valid)
    );

    data_ram u_data_ram (
        .clk          (clk),
        .rst          (rst),
        .dcache_valid (dcache_valid),
        .dcache_addr  (dcache_addr),
        .dcache_wdata (dcache_wdata),
        .dcache_wstrb (dcache_wstrb),
        .dcache_rdata (dcache_rdata),
        .dcache_ready (dcache_ready)
    );

endmodule

`default_nettype wire

// File: include/lsu_tb_cases.svh
`ifndef LSU_TB_CASES_SVH
`define LSU_TB_CASES_SVH

// Columns: op, byte address, write data, strobe, load size, unsigned, expected load data
// Memory starts at zero, each expected value follows the committed stores above it
localparam int NUM_CASES = 28;

localparam access_t CASES [NUM_CASES] = '{
    '{OP_STORE,    32'h010, 32'hdead_beef, 4'b1111, lsu_pkg::SIZE_WORD, 1'b0, 32'h0000_0000},
    '{OP_LOAD,     32'h010, 32'h0,         4'b0000, lsu_pkg::SIZE_WORD, 1'b0, 32'hdead_beef},
    // Every byte lane, both extensions
    '{OP_LOAD,     32'h010, 32'h0,         4'b0000, lsu_pkg::SIZE_BYTE, 1'b0, 32'hffff_ffef},
    '{OP_LOAD,     32'h010, 32'h0,         4'b0000, lsu_pkg::SIZE_BYTE, 1'b1, 32'h0000_00ef},
    '{OP_LOAD,     32'h011, 32'h0,         4'b0000, lsu_pkg::SIZE_BYTE, 1'b0, 32'hffff_ffbe},
    '{OP_LOAD,     32'h011, 32'h0,         4'b0000, lsu_pkg::SIZE_BYTE, 1'b1, 32'h0000_00be},
    '{OP_LOAD,     32'h012, 32'h0,         4'b0000, lsu_pkg::SIZE_BYTE, 1'b0, 32'hffff_ffad},
    '{OP_LOAD,     32'h012, 32'h0,         4'b0000, lsu_pkg::SIZE_BYTE, 1'b1, 32'h0000_00ad},
    '{OP_LOAD,     32'h013, 32'h0,         4'b0000, lsu_pkg::SIZE_BYTE, 1'b0, 32'hffff_ffde},
    '{OP_LOAD,     32'h013, 32'h0,         4'b0000, lsu_pkg::SIZE_BYTE, 1'b1, 32'h0000_00de},
    '{OP_LOAD,     32'h010, 32'h0,         4'b0000, lsu_pkg::SIZE_HALF, 1'b0, 32'hffff_beef},
    '{OP_LOAD,     32'h010, 32'h0,         4'b0000, lsu_pkg::SIZE_HALF, 1'b1, 32'h0000_beef},
    '{OP_LOAD,     32'h012, 32'h0,         4'b0000, lsu_pkg::SIZE_HALF, 1'b0, 32'hffff_dead},
    '{OP_LOAD,     32'h012, 32'h0,         4'b0000, lsu_pkg::SIZE_HALF, 1'b1, 32'h0000_dead},
    // Positive lanes stay positive
    '{OP_STORE,    32'h020, 32'h7f3c_6a51, 4'b1111, lsu_pkg::SIZE_WORD, 1'b0, 32'h0000_0000},
    '{OP_LOAD,     32'h021, 32'h0,         4'b0000, lsu_pkg::SIZE_BYTE, 1'b0, 32'h0000_006a},
    '{OP_LOAD,     32'h022, 32'h0,         4'b0000, lsu_pkg::SIZE_HALF, 1'b0, 32'h0000_7f3c},
    // Partial strobes merge into the word
    '{OP_STORE,    32'h020, 32'h0000_aa00, 4'b0010, lsu_pkg::SIZE_WORD, 1'b0, 32'h0000_0000},
    '{OP_STORE,    32'h020, 32'h5500_0000, 4'b1000, lsu_pkg::SIZE_WORD, 1'b0, 32'h0000_0000},
    '{OP_STORE,    32'h020, 32'h0066_0000, 4'b0100, lsu_pkg::SIZE_WORD, 1'b0, 32'h0000_0000},
    '{OP_LOAD,     32'h020, 32'h0,         4'b0000, lsu_pkg::SIZE_WORD, 1'b0, 32'h5566_aa51},
    '{OP_LOAD,     32'h021, 32'h0,         4'b0000, lsu_pkg::SIZE_BYTE, 1'b0, 32'hffff_ffaa},
    // Flushed store must not land
    '{OP_FLUSH,    32'h010, 32'h1111_1111, 4'b1111, lsu_pkg::SIZE_WORD, 1'b0, 32'h0000_0000},
    '{OP_LOAD,     32'h010, 32'h0,         4'b0000, lsu_pkg::SIZE_WORD, 1'b0, 32'hdead_beef},
    '{OP_LOAD,     32'h3fc, 32'h0,         4'b0000, lsu_pkg::SIZE_WORD, 1'b0, 32'h0000_0000},
    // Loads on consecutive cycles
    '{OP_LOAD,     32'h012, 32'h0,         4'b0000, lsu_pkg::SIZE_HALF, 1'b1, 32'h0000_dead},
    '{OP_LOAD_B2B, 32'h020, 32'h0,         4'b0000, lsu_pkg::SIZE_WORD, 1'b0, 32'h5566_aa51},
    '{OP_LOAD_B2B, 32'h023, 32'h0,         4'b0000, lsu_pkg::SIZE_BYTE, 1'b0, 32'h0000_0055}
};

`endif

// File: sim/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 16;
    localparam int CYCLES_PER_ROW = 12;
    localparam int READY_LIMIT = 8;

    localparam logic [1:0] OP_LOAD = 2'd0;
    localparam logic [1:0] OP_STORE = 2'd1;
    localparam logic [1:0] OP_FLUSH = 2'd2;
    localparam logic [1:0] OP_LOAD_B2B = 2'd3;

    typedef struct packed {
        logic [1:0]     op;
        mem_pkg::addr_t addr;
        mem_pkg::data_t wdata;
        mem_pkg::strb_t wstrb;
        lsu_pkg::size_e size;
        logic           is_unsigned;
        mem_pkg::data_t expected;
    } access_t;

`include "lsu_tb_cases.svh"

    localparam int WATCHDOG_CYCLES = NUM_CASES * CYCLES_PER_ROW + RESET_CYCLES;

    logic           clk = 1'b0;
    logic           rst;
    logic           cpu_valid;
    mem_pkg::addr_t cpu_addr;
    mem_pkg::data_t cpu_wdata;
    mem_pkg::strb_t cpu_wstrb;
    lsu_pkg::size_e cpu_size;
    logic           cpu_unsigned;
    logic           cpu_flush;
    logic           cpu_store_commit;
    logic           cpu_ready;
    mem_pkg::data_t cpu_rdata;
    logic           cpu_data_valid;

    integer seed;
    int     pass_count;
    int     fail_count;
    int     row_errors;
    string  cur_label;

    lsu_top UUT (
        .clk              (clk),
        .rst              (rst),
        .cpu_valid        (cpu_valid),
        .cpu_addr         (cpu_addr),
        .cpu_wdata        (cpu_wdata),
        .cpu_wstrb        (cpu_wstrb),
        .cpu_size         (cpu_size),
        .cpu_unsigned     (cpu_unsigned),
        .cpu_flush        (cpu_flush),
        .cpu_store_commit (cpu_store_commit),
        .cpu_ready        (cpu_ready),
        .cpu_rdata        (cpu_rdata),
        .cpu_data_valid   (cpu_data_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_data(input string name, input mem_pkg::data_t expected,
                              input mem_pkg::data_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected 0x%08h, got 0x%08h (%s)",
                     name, expected, actual, cur_label);
            row_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error: %s expected 0x%0h, got 0x%0h (%s)",
                     name, expected, actual, cur_label);
            row_errors++;
        end
    endtask

    function automatic string op_name(input logic [1:0] op);
        case (op)
            OP_STORE: return "store";
            OP_FLUSH: return "flushed store";
            OP_LOAD_B2B: return "chained load";
            default: return "load";
        endcase
    endfunction

    function automatic string row_label(input int idx);
        return $sformatf("row %0d %s at 0x%03h", idx, op_name(CASES[idx].op), CASES[idx].addr);
    endfunction

    // One line per finished test
    task automatic finish_test();
        if (row_errors == 0) begin
            pass_count++;
            $display("%s: ok", cur_label);
        end else begin
            fail_count++;
            $display("%s: %0d error(s)", cur_label, row_errors);
        end
        row_errors = 0;
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!cpu_ready && waited < READY_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!cpu_ready) begin
            $display("%s: cpu_ready did not return within %0d cycles", cur_label, READY_LIMIT);
            row_errors++;
        end
    endtask

    task automatic release_bus();
        cpu_valid = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_wstrb = '0;
    endtask

    task automatic drive_load(input int idx);
        cpu_valid    = 1'b1;
        cpu_addr     = CASES[idx].addr;
        cpu_wdata    = '0;
        cpu_wstrb    = '0;
        cpu_size     = CASES[idx].size;
        cpu_unsigned = CASES[idx].is_unsigned;
    endtask

    // Response is due in the cycle after acceptance
    task automatic check_load(input int idx);
        if (cpu_data_valid !== 1'b1) begin
            $display("%s: cpu_data_valid missing in the cycle after acceptance", cur_label);
            row_errors++;
        end else begin
            check_data("cpu_rdata", CASES[idx].expected, cpu_rdata);
        end
        check_flag("cpu_ready", 1'b1, cpu_ready);
    endtask

    task automatic run_load_chain(inout int idx);
        wait_ready();
        drive_load(idx);
        @(negedge clk);
        // Next load goes out while this one is answered
        while (idx + 1 < NUM_CASES && CASES[idx + 1].op == OP_LOAD_B2B) begin
            check_load(idx);
            finish_test();
            idx++;
            cur_label = row_label(idx);
            drive_load(idx);
            @(negedge clk);
        end
        release_bus();
        check_load(idx);
        finish_test();
        idx++;
    endtask

    task automatic run_store(input int idx);
        int delay;
        wait_ready();
        cpu_valid    = 1'b1;
        cpu_addr     = CASES[idx].addr;
        cpu_wdata    = CASES[idx].wdata;
        cpu_wstrb    = CASES[idx].wstrb;
        cpu_size     = lsu_pkg::SIZE_WORD;
        cpu_unsigned = 1'b0;
        @(negedge clk);
        release_bus();
        check_flag("cpu_ready", 1'b0, cpu_ready);
        delay = 1 + int'($unsigned($random(seed)) % 4);
        cur_label = $sformatf("%s, commit delay %0d", cur_label, delay);
        for (int k = 1; k < delay; k++) begin
            @(negedge clk);
            check_flag("cpu_ready", 1'b0, cpu_ready);
        end
        if (CASES[idx].op == OP_FLUSH) begin
            cpu_flush = 1'b1;
        end else begin
            cpu_store_commit = 1'b1;
        end
        @(negedge clk);
        cpu_flush        = 1'b0;
        cpu_store_commit = 1'b0;
        if (CASES[idx].op == OP_FLUSH) begin
            check_flag("cpu_ready", 1'b1, cpu_ready);
        end else begin
            check_flag("cpu_ready", 1'b0, cpu_ready);
            @(negedge clk);
            // Store acknowledge cycle carries no load data
            check_flag("cpu_data_valid", 1'b0, cpu_data_valid);
            wait_ready();
        end
        finish_test();
    endtask

    initial begin
        int row;
        seed             = 69;
        pass_count       = 0;
        fail_count       = 0;
        row_errors       = 0;
        rst              = 1'b1;
        cpu_valid        = 1'b0;
        cpu_addr         = '0;
        cpu_wdata        = '0;
        cpu_wstrb        = '0;
        cpu_size         = lsu_pkg::SIZE_WORD;
        cpu_unsigned     = 1'b0;
        cpu_flush        = 1'b0;
        cpu_store_commit = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        cur_label = "reset";
        check_flag("cpu_ready", 1'b1, cpu_ready);
        check_flag("cpu_data_valid", 1'b0, cpu_data_valid);
        finish_test();
        row = 0;
        while (row < NUM_CASES) begin
            cur_label = row_label(row);
            if (CASES[row].op == OP_STORE || CASES[row].op == OP_FLUSH) begin
                run_store(row);
                row++;
            end else begin
                run_load_chain(row);
            end
        end
        $display("tests: %0d ok, %0d with errors", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: lsu.f
+incdir+include
src/mem_pkg.sv
src/lsu_pkg.sv
src/lsu_ctrl.sv
src/store_buffer.sv
src/load_align.sv
src/data_ram.sv
src/lsu_top.sv
sim/lsu_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= lsu_tb
FILELIST  ?= lsu.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Pass only when the testbench prints the pass message on a line of its own
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
